// File: hw/retire_prof_pkg.sv
package retire_prof_pkg;

    ////////////////////////////////////////////////////////////
    // Window markers

    // ADDI to x0 with immediates 12 and 13
    localparam logic [31:0] START_MARKER_NOP = 32'h00C00013;
    localparam logic [31:0] END_MARKER_NOP   = 32'h00D00013;

    ////////////////////////////////////////////////////////////
    // Instruction decode

    // Major opcode field, instruction bits 6 to 2
    typedef enum logic [4:0] {
        LOAD     = 5'b00000,
        LOAD_FP  = 5'b00001,
        MISC_MEM = 5'b00011,
        OP_IMM   = 5'b00100,
        AUIPC    = 5'b00101,
        STORE    = 5'b01000,
        STORE_FP = 5'b01001,
        AMO      = 5'b01011,
        OP       = 5'b01100,
        LUI      = 5'b01101,
        MADD     = 5'b10000,
        MSUB     = 5'b10001,
        NMSUB    = 5'b10010,
        NMADD    = 5'b10011,
        OP_FP    = 5'b10100,
        BRANCH   = 5'b11000,
        JALR     = 5'b11001,
        JAL      = 5'b11011,
        SYSTEM   = 5'b11100
    } opcode_t;

    localparam int NUM_CATS = 8;

    // Bit position of each category in the mask and in the counter array
    typedef enum logic [2:0] {
        CAT_ALU   = 3'd0,
        CAT_BR    = 3'd1,
        CAT_MUL   = 3'd2,
        CAT_DIV   = 3'd3,
        CAT_LOAD  = 3'd4,
        CAT_STORE = 3'd5,
        CAT_FPU   = 3'd6,
        CAT_MISC  = 3'd7
    } mix_cat_t;

    typedef logic [NUM_CATS-1:0] mix_mask_t;

    ////////////////////////////////////////////////////////////
    // Window control and pipeline payloads

    typedef enum logic [1:0] {
        WIN_IDLE       = 2'd0,
        WIN_COLLECTING = 2'd1,
        WIN_DONE       = 2'd2
    } window_state_t;

    // One retire port
    typedef struct packed {
        logic        valid;
        logic [31:0] instr;
    } retire_slot_t;

    // One port after decode
    typedef struct packed {
        logic      counted;
        mix_mask_t mask;
    } classified_t;

endpackage

// File: hw/retire_capture.sv
`timescale 1ns/10ps

module retire_capture #(
    parameter int RETIRE_PORTS = 2
) (
    input  logic                                          clk,
    input  logic                                          reset,
    input  retire_prof_pkg::retire_slot_t [RETIRE_PORTS-1:0] retire,
    input  logic                                          clear,
    output retire_prof_pkg::retire_slot_t [RETIRE_PORTS-1:0] tagged_slots,
    output retire_prof_pkg::window_state_t                   window_state
);
    import retire_prof_pkg::*;

    logic          start_seen;
    logic          end_seen;
    logic          count_en;
    window_state_t next_state;

    ////////////////////////////////////////////////////////////
    // Marker detection across all ports

    always_comb begin
        start_seen = 1'b0;
        end_seen   = 1'b0;
        for (int p = 0; p < RETIRE_PORTS; p++) begin
            start_seen |= retire[p].valid && (retire[p].instr == START_MARKER_NOP);
            end_seen   |= retire[p].valid && (retire[p].instr == END_MARKER_NOP);
        end
    end

    ////////////////////////////////////////////////////////////
    // Window FSM

    always_comb begin
        next_state = window_state;
        case (window_state)
            WIN_IDLE: begin
                if (start_seen) begin
                    next_state = WIN_COLLECTING;
                end
            end
            WIN_COLLECTING: begin
                if (end_seen) begin
                    next_state = WIN_DONE;
                end
            end
            // Closed window stays closed until software clears it
            WIN_DONE: next_state = WIN_DONE;
            default:  next_state = WIN_IDLE;
        endcase
        // Clear beats any marker in the same cycle
        if (clear) begin
            next_state = WIN_IDLE;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            window_state <= WIN_IDLE;
        end else begin
            window_state <= next_state;
        end
    end

    ////////////////////////////////////////////////////////////
    // Slot register

    // Count only inside an open window and never in a marker cycle
    assign count_en = (window_state == WIN_COLLECTING) && !start_seen && !end_seen && !clear;

    always_ff @(posedge clk) begin
        for (int p = 0; p < RETIRE_PORTS; p++) begin
            tagged_slots[p].instr <= retire[p].instr;
            if (reset) begin
                tagged_slots[p].valid <= 1'b0;
            end else begin
                tagged_slots[p].valid <= retire[p].valid && count_en;
            end
        end
    end

endmodule

// File: hw/mix_classifier.sv
`timescale 1ns/10ps

module mix_classifier #(
    parameter int RETIRE_PORTS = 2
) (
    input  logic                                          clk,
    input  logic                                          reset,
    input  retire_prof_pkg::retire_slot_t [RETIRE_PORTS-1:0] tagged_slots,
    output retire_prof_pkg::classified_t  [RETIRE_PORTS-1:0] classified
);
    import retire_prof_pkg::*;

    mix_mask_t [RETIRE_PORTS-1:0] next_mask;

    ////////////////////////////////////////////////////////////
    // Category decode

    // M extension lives under OP with funct7 bit 25 set
    function automatic mix_mask_t classify(input retire_slot_t slot);
        opcode_t   op;
        logic      is_muldiv;
        logic      is_div;
        mix_mask_t mask;

        op        = opcode_t'(slot.instr[6:2]);
        is_muldiv = (op == OP) && slot.instr[25];
        // funct3 bit 2 splits MUL* from DIV/REM
        is_div    = slot.instr[14];
        mask      = '0;

        mask[CAT_ALU]   = (op inside {OP, OP_IMM, AUIPC, LUI}) && !is_muldiv;
        mask[CAT_BR]    = op inside {BRANCH, JAL, JALR};
        mask[CAT_MUL]   = is_muldiv && !is_div;
        mask[CAT_DIV]   = is_muldiv && is_div;
        // AMO is both a read and a write of memory
        mask[CAT_LOAD]  = op inside {LOAD, LOAD_FP, AMO};
        mask[CAT_STORE] = op inside {STORE, STORE_FP, AMO};
        mask[CAT_FPU]   = op inside {MADD, MSUB, NMSUB, NMADD, OP_FP};
        mask[CAT_MISC]  = op inside {SYSTEM, MISC_MEM};

        if (!slot.valid) begin
            mask = '0;
        end
        return mask;
    endfunction

    always_comb begin
        for (int p = 0; p < RETIRE_PORTS; p++) begin
            next_mask[p] = classify(tagged_slots[p]);
        end
    end

    ////////////////////////////////////////////////////////////
    // Output stage

    always_ff @(posedge clk) begin
        if (reset) begin
            classified <= '0;
        end else begin
            for (int p = 0; p < RETIRE_PORTS; p++) begin
                classified[p].counted <= tagged_slots[p].valid;
                classified[p].mask    <= next_mask[p];
            end
        end
    end

endmodule

// File: hw/mix_counters.sv
`timescale 1ns/10ps

module mix_counters #(
    parameter int RETIRE_PORTS = 2,
    parameter int COUNT_W      = 32
) (
    input  logic                                                clk,
    input  logic                                                reset,
    input  retire_prof_pkg::classified_t [RETIRE_PORTS-1:0]       classified,
    input  logic                                                clear,
    output logic [COUNT_W-1:0]                                  total_count,
    output logic [retire_prof_pkg::NUM_CATS-1:0][COUNT_W-1:0]    cat_counts
);
    import retire_prof_pkg::*;

    // Enough bits to hold a count of every port in one cycle
    localparam int SUM_W = $clog2(RETIRE_PORTS + 1);

    logic [SUM_W-1:0]                total_inc;
    logic [NUM_CATS-1:0][SUM_W-1:0]  cat_inc;

    ////////////////////////////////////////////////////////////
    // Per-cycle increments

    always_comb begin
        total_inc = '0;
        cat_inc   = '0;
        for (int p = 0; p < RETIRE_PORTS; p++) begin
            total_inc = total_inc + SUM_W'(classified[p].counted);
            for (int c = 0; c < NUM_CATS; c++) begin
                cat_inc[c] = cat_inc[c] + SUM_W'(classified[p].mask[c]);
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Accumulators

    // Free-running wrap at COUNT_W, clear drops the update of that cycle
    always_ff @(posedge clk) begin
        if (reset || clear) begin
            total_count <= '0;
            cat_counts  <= '0;
        end else begin
            total_count <= total_count + COUNT_W'(total_inc);
            for (int c = 0; c < NUM_CATS; c++) begin
                cat_counts[c] <= cat_counts[c] + COUNT_W'(cat_inc[c]);
            end
        end
    end

endmodule

// File: hw/apb_stat_regs.sv
`timescale 1ns/10ps

module apb_stat_regs #(
    parameter int COUNT_W = 32
) (
    input  logic                                              clk,
    input  logic                                              reset,
    input  logic [7:0]                                        paddr,
    input  logic                                              psel,
    input  logic                                              penable,
    input  logic                                              pwrite,
    input  logic [31:0]                                       pwdata,
    output logic [31:0]                                       prdata,
    output logic                                              pready,
    output logic                                              pslverr,
    input  retire_prof_pkg::window_state_t                      window_state,
    input  logic [COUNT_W-1:0]                                total_count,
    input  logic [retire_prof_pkg::NUM_CATS-1:0][COUNT_W-1:0]  cat_counts,
    output logic                                              clear
);
    import retire_prof_pkg::*;

    // Word index of the last category counter
    localparam logic [5:0] LAST_WORD = 6'(NUM_CATS + 1);

    logic [5:0]  word_idx;
    logic        addr_hit;
    logic        setup_phase;
    logic        access_done;
    logic [31:0] rd_mux;

    ////////////////////////////////////////////////////////////
    // Address decode

    assign word_idx    = paddr[7:2];
    assign addr_hit    = (paddr[1:0] == 2'b00) && (word_idx <= LAST_WORD);
    assign setup_phase = psel && !penable;
    assign access_done = psel && penable && pready;

    // No wait states ever
    assign pready = 1'b1;

    always_comb begin
        rd_mux = '0;
        if (addr_hit) begin
            case (word_idx)
                6'd0:    rd_mux = 32'(window_state);
                6'd1:    rd_mux = 32'(total_count);
                // Categories follow in mask order
                default: rd_mux = 32'(cat_counts[3'(word_idx - 6'd2)]);
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // Read data and error, captured in setup for the access phase

    always_ff @(posedge clk) begin
        if (setup_phase) begin
            prdata <= rd_mux;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pslverr <= 1'b0;
        end else if (setup_phase) begin
            pslverr <= !addr_hit;
        end else if (access_done) begin
            pslverr <= 1'b0;
        end
    end

    ////////////////////////////////////////////////////////////
    // Clear control

    // Pulse lands on the edge that completes the write
    assign clear = access_done && pwrite && addr_hit && (word_idx == 6'd0) && pwdata[0];

endmodule

// File: hw/retire_profiler.sv
`timescale 1ns/10ps

module retire_profiler #(
    parameter int RETIRE_PORTS = 2,
    parameter int COUNT_W      = 32
) (
    input  logic                                          clk,
    input  logic                                          reset,
    input  retire_prof_pkg::retire_slot_t [RETIRE_PORTS-1:0] retire,
    input  logic [7:0]                                    paddr,
    input  logic                                          psel,
    input  logic                                          penable,
    input  logic                                          pwrite,
    input  logic [31:0]                                   pwdata,
    output logic [31:0]                                   prdata,
    output logic                                          pready,
    output logic                                          pslverr
);
    import retire_prof_pkg::*;

    retire_slot_t [RETIRE_PORTS-1:0]      tagged_slots;
    classified_t  [RETIRE_PORTS-1:0]      classified;
    window_state_t                        window_state;
    logic [COUNT_W-1:0]                   total_count;
    logic [NUM_CATS-1:0][COUNT_W-1:0]     cat_counts;
    logic                                 clear;

    ////////////////////////////////////////////////////////////
    // Retire stream pipeline, three stages to the counters

    retire_capture #(
        .RETIRE_PORTS (RETIRE_PORTS)
    ) u_capture (
        .clk          (clk),
        .reset        (reset),
        .retire       (retire),
        .clear        (clear),
        .tagged_slots (tagged_slots),
        .window_state (window_state)
    );

    mix_classifier #(
        .RETIRE_PORTS (RETIRE_PORTS)
    ) u_classifier (
        .clk          (clk),
        .reset        (reset),
        .tagged_slots (tagged_slots),
        .classified   (classified)
    );

    mix_counters #(
        .RETIRE_PORTS (RETIRE_PORTS),
        .COUNT_W      (COUNT_W)
    ) u_counters (
        .clk         (clk),
        .reset       (reset),
        .classified  (classified),
        .clear       (clear),
        .total_count (total_count),
        .cat_counts  (cat_counts)
    );

    ////////////////////////////////////////////////////////////
    // Software access

    apb_stat_regs #(
        .COUNT_W (COUNT_W)
    ) u_regs (
        .clk          (clk),
        .reset        (reset),
        .paddr        (paddr),
        .psel         (psel),
        .penable      (penable),
        .pwrite       (pwrite),
        .pwdata       (pwdata),
        .prdata       (prdata),
        .pready       (pready),
        .pslverr      (pslverr),
        .window_state (window_state),
        .total_count  (total_count),
        .cat_counts   (cat_counts),
        .clear        (clear)
    );

endmodule

// File: sim/tb_retire_profiler.sv
`timescale 1ns/10ps

module tb_retire_profiler;
    import retire_prof_pkg::*;

    localparam int NPORTS = 2;
    // About 1600 cycles of traffic and readout below, with a wide margin
    localparam int MAX_CYCLES = 4000;
    // addi x1, x0, 1
    localparam logic [31:0] ADDI_X1 = 32'h00100093;
    localparam logic [4:0] OP_LIST [19] = '{
        LOAD, LOAD_FP, MISC_MEM, OP_IMM, AUIPC, STORE, STORE_FP, AMO, OP, LUI,
        MADD, MSUB, NMSUB, NMADD, OP_FP, BRANCH, JALR, JAL, SYSTEM
    };

    logic                      clk;
    logic                      reset;
    retire_slot_t [NPORTS-1:0] retire;
    logic [7:0]                paddr;
    logic                      psel;
    logic                      penable;
    logic                      pwrite;
    logic [31:0]               pwdata;
    logic [31:0]               prdata;
    logic                      pready;
    logic                      pslverr;

    logic [31:0]   lcg_state;
    int            cycle_count;
    window_state_t exp_win;
    logic [31:0]   exp_total;
    logic [31:0]   exp_cat [NUM_CATS];

    retire_profiler #(
        .RETIRE_PORTS (NPORTS),
        .COUNT_W      (32)
    ) DUT (
        .clk     (clk),
        .reset   (reset),
        .retire  (retire),
        .paddr   (paddr),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("RESULT: FAIL");
            $fatal(1, "timeout");
        end
    end

    ////////////////////////////////////////////////////////////
    // Stimulus generation and reference model

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // Expected category mask straight from the instruction-mix rules
    function automatic mix_mask_t classify_ref(input logic [31:0] instr);
        mix_mask_t m;
        m = '0;
        case (instr[6:2])
            5'b01100: begin
                if (!instr[25]) m[CAT_ALU] = 1'b1;
                else if (instr[14]) m[CAT_DIV] = 1'b1;
                else m[CAT_MUL] = 1'b1;
            end
            5'b00100, 5'b00101, 5'b01101: m[CAT_ALU] = 1'b1;
            5'b11000, 5'b11001, 5'b11011: m[CAT_BR] = 1'b1;
            5'b00000, 5'b00001: m[CAT_LOAD] = 1'b1;
            5'b01000, 5'b01001: m[CAT_STORE] = 1'b1;
            // AMO reads and writes
            5'b01011: begin
                m[CAT_LOAD]  = 1'b1;
                m[CAT_STORE] = 1'b1;
            end
            5'b10000, 5'b10001, 5'b10010, 5'b10011, 5'b10100: m[CAT_FPU] = 1'b1;
            5'b11100, 5'b00011: m[CAT_MISC] = 1'b1;
            default: m = '0;
        endcase
        return m;
    endfunction

    function automatic retire_slot_t random_slot();
        retire_slot_t s;
        logic [31:0]  r;
        logic [31:0]  w;
        r = lcg_next();
        w = lcg_next();
        w[6:2] = OP_LIST[int'(r[23:16]) % 19];
        w[1:0] = 2'b11;
        // Roughly one word in 64 collides with a marker
        if (r[13:8] == 6'd0) begin
            w = r[14] ? END_MARKER_NOP : START_MARKER_NOP;
        end
        if (w == START_MARKER_NOP || w == END_MARKER_NOP) begin
            w = ADDI_X1;
        end
        s.valid = (r[31:30] != 2'b00);
        s.instr = w;
        return s;
    endfunction

    // Kind 0 is MUL, 1 is DIV, anything else an AMO
    function automatic retire_slot_t directed_slot(input int kind);
        retire_slot_t s;
        logic [31:0]  w;
        w = lcg_next();
        if (kind == 0 || kind == 1) begin
            w[6:0]   = 7'b0110011;
            w[31:25] = 7'b0000001;
            w[14]    = (kind == 1);
        end else begin
            w[6:0] = 7'b0101111;
        end
        s.valid = 1'b1;
        s.instr = w;
        return s;
    endfunction

    task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            $display("ERROR at %0t: %s got %h expected %h", $time, what, got, exp);
            $display("RESULT: FAIL");
            $fatal(1, "mismatch");
        end
    endtask

    // Drives one retire cycle and applies the window rule to the expected counters
    task automatic drive_cycle(input retire_slot_t [NPORTS-1:0] slots);
        logic      start_hit;
        logic      end_hit;
        mix_mask_t m;
        @(negedge clk);
        retire    = slots;
        start_hit = 1'b0;
        end_hit   = 1'b0;
        for (int p = 0; p < NPORTS; p++) begin
            start_hit |= slots[p].valid && (slots[p].instr == START_MARKER_NOP);
            end_hit   |= slots[p].valid && (slots[p].instr == END_MARKER_NOP);
        end
        if (exp_win == WIN_COLLECTING && !start_hit && !end_hit) begin
            for (int p = 0; p < NPORTS; p++) begin
                if (slots[p].valid) begin
                    exp_total = exp_total + 32'd1;
                    m = classify_ref(slots[p].instr);
                    for (int c = 0; c < NUM_CATS; c++) begin
                        exp_cat[c] = exp_cat[c] + 32'(m[c]);
                    end
                end
            end
        end
        if (exp_win == WIN_IDLE && start_hit) begin
            exp_win = WIN_COLLECTING;
        end else if (exp_win == WIN_COLLECTING && end_hit) begin
            exp_win = WIN_DONE;
        end
    endtask

    task automatic random_cycles(input int n);
        retire_slot_t [NPORTS-1:0] slots;
        for (int i = 0; i < n; i++) begin
            for (int p = 0; p < NPORTS; p++) begin
                slots[p] = random_slot();
            end
            drive_cycle(slots);
        end
    endtask

    // Marker on one port, a valid random word on the others
    task automatic marker_cycle(input int port, input logic [31:0] word);
        retire_slot_t [NPORTS-1:0] slots;
        for (int p = 0; p < NPORTS; p++) begin
            slots[p]       = random_slot();
            slots[p].valid = 1'b1;
        end
        slots[port].instr = word;
        drive_cycle(slots);
    endtask

    // Idle slots until the pipeline has emptied
    task automatic drain();
        for (int i = 0; i < 6; i++) begin
            drive_cycle('0);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // APB master

    task automatic apb_read(input logic [7:0] addr, output logic [31:0] data,
                            output logic err);
        @(negedge clk);
        paddr   = addr;
        pwrite  = 1'b0;
        psel    = 1'b1;
        penable = 1'b0;
        @(negedge clk);
        penable = 1'b1;
        check_eq(32'(pready), 32'd1, "read pready");
        data = prdata;
        err  = pslverr;
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
        @(negedge clk);
        paddr   = addr;
        pwdata  = data;
        pwrite  = 1'b1;
        psel    = 1'b1;
        penable = 1'b0;
        @(negedge clk);
        penable = 1'b1;
        check_eq(32'(pready), 32'd1, "write pready");
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    // Reads status and every counter and compares with the model
    task automatic check_all(input string tag);
        logic [31:0] data;
        logic        err;
        apb_read(8'h00, data, err);
        check_eq(32'(err), 32'd0, {tag, " status pslverr"});
        check_eq(data, 32'(exp_win), {tag, " status"});
        apb_read(8'h04, data, err);
        check_eq(32'(err), 32'd0, {tag, " total pslverr"});
        check_eq(data, exp_total, {tag, " total"});
        for (int c = 0; c < NUM_CATS; c++) begin
            apb_read(8'(8 + 4 * c), data, err);
            check_eq(32'(err), 32'd0, $sformatf("%s cat %0d pslverr", tag, c));
            check_eq(data, exp_cat[c], $sformatf("%s cat %0d", tag, c));
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Test sequence

    initial begin
        retire_slot_t [NPORTS-1:0] slots;
        logic [31:0]               data;
        logic                      err;
        lcg_state   = 32'h6921b9af;
        cycle_count = 0;
        reset       = 1'b1;
        retire      = '0;
        paddr       = '0;
        psel        = 1'b0;
        penable     = 1'b0;
        pwrite      = 1'b0;
        pwdata      = '0;
        exp_win     = WIN_IDLE;
        exp_total   = '0;
        for (int c = 0; c < NUM_CATS; c++) begin
            exp_cat[c] = '0;
        end
        repeat (4) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        check_all("after reset");

        // Traffic before any start marker
        random_cycles(200);
        drain();
        check_all("pre-window");

        marker_cycle(0, START_MARKER_NOP);
        random_cycles(500);
        drain();
        check_all("open window");

        // End marker on the second port, then a start that must not reopen
        marker_cycle(1, END_MARKER_NOP);
        random_cycles(200);
        marker_cycle(0, START_MARKER_NOP);
        random_cycles(50);
        drain();
        check_all("closed window");

        apb_write(8'h00, 32'h1);
        exp_win   = WIN_IDLE;
        exp_total = '0;
        for (int c = 0; c < NUM_CATS; c++) begin
            exp_cat[c] = '0;
        end
        check_all("after clear");

        // Second window with M-extension and AMO words on both ports
        marker_cycle(1, START_MARKER_NOP);
        for (int i = 0; i < 400; i++) begin
            if (i % 4 == 0) begin
                slots[0] = directed_slot((i / 4) % 3);
                slots[1] = directed_slot((i / 4 + 1) % 3);
                drive_cycle(slots);
            end else begin
                random_cycles(1);
            end
        end
        drain();
        check_all("second window");

        apb_read(8'h28, data, err);
        check_eq(32'(err), 32'd1, "unmapped 0x28 pslverr");
        check_eq(data, 32'd0, "unmapped 0x28 prdata");
        apb_read(8'hfc, data, err);
        check_eq(32'(err), 32'd1, "unmapped 0xfc pslverr");
        check_eq(data, 32'd0, "unmapped 0xfc prdata");

        $display("RESULT: PASS");
        $finish;
    end

endmodule

// File: retire_profiler.f
hw/retire_prof_pkg.sv
hw/retire_capture.sv
hw/mix_classifier.sv
hw/mix_counters.sv
hw/apb_stat_regs.sv
hw/retire_profiler.sv
sim/tb_retire_profiler.sv

// File: Makefile
# Verilator flow for the retire-stream profiler

TOP = tb_retire_profiler

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -f retire_profiler.f \
		--top-module $(TOP) --Mdir obj_dir -o $(TOP)

run: compile
	./obj_dir/$(TOP) | tee sim.log
	@grep -q "RESULT: PASS" sim.log || \
		(echo "Simulation failed, see sim.log"; exit 1)

clean:
	rm -rf obj_dir sim.log
